//--- verif/kr580_chk.sv
`timescale 1ns/1ps

module kr580_chk
(
    input logic              clock,
    input logic              reset_n,
    input logic              we,
    input logic              sel_hl,
    input logic              is_jp,
    input isa_pkg::t_state_e state
);
    import isa_pkg::*;

    // Stores always go out at HL
    store_at_hl: assert property (@(posedge clock) disable iff (!reset_n)
        we |-> sel_hl)
        else $error("we is high while the address select is on PC");

    // --------------------------------------------------
    // T-state sequence
    // --------------------------------------------------
    t2_only_on_jump: assert property (@(posedge clock) disable iff (!reset_n)
        (state == t2) |-> is_jp)
        else $error("t2 reached by an instruction that is not a jump");

    // Write strobe dropped by reset
    no_we_after_reset: assert property (@(posedge clock)
        !reset_n |=> !we)
        else $error("we is high in the cycle after reset");

endmodule

bind sequencer kr580_chk u_chk (
    .clock   (clock),
    .reset_n (reset_n),
    .we      (we),
    .sel_hl  (sel_hl),
    .is_jp   (is_jp),
    .state   (state)
);

//--- verif/kr580_tests.hex
// Word 0: program length P (bits 23:8) and write count W (bits 7:0)
// Then P program bytes from address 0, then W writes as address (23:8) and data (7:0)
00C42A
// Loads, stores at 8000..8004, reloads through HL
26 80 2E 00 06 11 0E 22 16 33 1E 44 3E 55 70 2C
71 2C 72 2C 73 2C 77 74 75 3E 99 47 48 51 5A 73
2E 00 7E 2E 02 46 2C 4E 26 90 77 2C 70 2C 71 2C
// ALU on register, (HL) and immediate, results at 9006
3E 3A 80 77 86 77 C6 30 77 88 77 8E 77 CE 90 77
90 77 96 77 D6 05 77 98 77 9E 77 DE 01 77 A0 77
3E F0 A6 77 E6 1F 77 A8 77 3E 5A AE 77 EE FF 77
B0 77 3E 48 B6 77 3E 40 F6 02 77 B8 77 BE 77 FE
// Conditional jumps, INC/DEC wrap, JP and HALT
50 77 DA 78 00 3E EE 77 D2 7E 00 3E C1 77 AF CA
85 00 3E EE 77 C2 8B 00 3E C2 77 D2 91 00 3E EE
77 06 FF 04 CA 9A 00 3E EE 77 78 77 05 CA A2 00
78 77 0E 01 0D CA AB 00 3E EE 77 0D 79 77 3C C2
B3 00 77 3E 7F 3C D2 BC 00 3E EE 77 77 C3 C3 00
3E EE 77 76
// Expected writes in order
800011 800122 800233 800344 800455 800480 800404 800499
900311 900433 900544 90066D 9006DA 90060A 90063E 90067C
90060C 9006D9 900600 9006FB 9006C7 900600 9006FF 900633
900630 900610 900623 900679 900686 9006B7 9006FF 900642
900642 900642 900642 9006C1 9006C2 900600 9006FF 9006FF
900600 900680

//--- verif/tb_kr580.sv
`timescale 1ns/1ps

module tb_kr580;
    import bus_pkg::*;
    import isa_pkg::*;

    localparam int word_count = 1024;

    logic        clock;
    logic        reset_n;
    data_t       rd_data;
    addr_t       address;
    logic        we;
    data_t       out;

    // 64 KiB memory and the raw words of the test file
    data_t       mem [0:65535];
    logic [23:0] words [0:word_count-1];

    int          prog_len;
    int          write_total;
    int          write_index;
    int          cycle_count;
    int          cycle_limit;
    int          value_errors;
    int          count_errors;
    int          halt_seen;
    addr_t       halt_address;
    logic        timed_out;

    kr580_core u_dut (
        .clock   (clock),
        .reset_n (reset_n),
        .in      (rd_data),
        .address (address),
        .we      (we),
        .out     (out)
    );

    // Memory answers in the same cycle
    assign rd_data = mem[address];

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic data_t fill_byte(input addr_t a);
        return a[15:8] ^ {a[6:0], a[7]} ^ 8'h3C;
    endfunction

    task automatic load_image();
        int i;
        for (i = 0; i < 65536; i++) begin
            mem[i] = fill_byte(addr_t'(i));
        end
        $readmemh("verif/kr580_tests.hex", words);
        prog_len    = words[0][23:8];
        write_total = words[0][7:0];
        for (i = 0; i < prog_len; i++) begin
            mem[i] = words[1 + i][7:0];
        end
    endtask

    // Compare one store against the next expected record
    task automatic check_write();
        logic [23:0] rec;
        if (write_index >= write_total) begin
            $display("Unexpected extra write to %h with data %h", address, out);
            count_errors++;
        end else begin
            rec = words[1 + prog_len + write_index];
            if (address !== rec[23:8]) begin
                $display("[FAIL] address = %h, expected %h (write %0d)",
                         address, rec[23:8], write_index);
                value_errors++;
            end
            if (out !== rec[7:0]) begin
                $display("[FAIL] out = %h, expected %h (write %0d)",
                         out, rec[7:0], write_index);
                value_errors++;
            end
        end
        write_index++;
    endtask

    // --------------------------------------------------
    // Memory writes, cycle count, HALT detection
    // --------------------------------------------------
    always @(posedge clock) begin
        if (reset_n) begin
            cycle_count++;
            if (we) begin
                check_write();
                mem[address] <= out;
            end else if (mem[address] == op_halt) begin
                // Back-to-back fetches of the same HALT byte
                if (halt_seen > 0 && address == halt_address) begin
                    halt_seen++;
                end else begin
                    halt_seen = 1;
                end
                halt_address = address;
            end else begin
                halt_seen = 0;
            end
        end
    end

    initial begin
        reset_n      = 1'b0;
        value_errors = 0;
        count_errors = 0;
        write_index  = 0;
        cycle_count  = 0;
        halt_seen    = 0;
        halt_address = '0;
        timed_out    = 1'b0;
        load_image();
        cycle_limit = 3 * prog_len + 50;

        repeat (5) @(negedge clock);
        reset_n = 1'b1;

        while (halt_seen < 2 && cycle_count < cycle_limit) begin
            @(negedge clock);
        end

        if (halt_seen < 2) begin
            $display("Timeout: the program did not halt within %0d cycles", cycle_limit);
            timed_out = 1'b1;
        end else if (halt_address != addr_t'(prog_len - 1)) begin
            $display("[FAIL] address = %h at HALT, expected %h",
                     halt_address, addr_t'(prog_len - 1));
            value_errors++;
        end
        if (write_index < write_total) begin
            $display("Missing writes: only %0d of %0d expected writes were made",
                     write_index, write_total);
            count_errors++;
        end

        $display("Errors: %0d value, %0d count, %0d timeout",
                 value_errors, count_errors, timed_out);
        if (value_errors == 0 && count_errors == 0 && !timed_out) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- verilog.f
verilog/bus_pkg.sv
verilog/isa_pkg.sv
verilog/reg_wr_if.sv
verilog/alu_if.sv
verilog/alu.sv
verilog/register_file.sv
verilog/sequencer.sv
verilog/kr580_core.sv
verif/kr580_chk.sv
verif/tb_kr580.sv

//--- verilog/alu.sv
`timescale 1ns/1ps

module alu
(
    alu_if.compute alu
);
    import isa_pkg::*;

    logic [8:0] wide;
    logic       is_logic;
    logic       is_sub;
    logic       overflow;

    // Bit 8 holds the carry or borrow out of bit 7
    always_comb begin
        unique case (alu.op)
            alu_add: wide = {1'b0, alu.lhs} + {1'b0, alu.rhs};
            alu_adc: wide = {1'b0, alu.lhs} + {1'b0, alu.rhs} + {8'b0, alu.carry_in};
            alu_sub,
            alu_cp:  wide = {1'b0, alu.lhs} - {1'b0, alu.rhs};
            alu_sbc: wide = {1'b0, alu.lhs} - {1'b0, alu.rhs} - {8'b0, alu.carry_in};
            alu_and: wide = {1'b0, alu.lhs & alu.rhs};
            alu_xor: wide = {1'b0, alu.lhs ^ alu.rhs};
            alu_or:  wide = {1'b0, alu.lhs | alu.rhs};
        endcase
    end

    assign is_logic = alu.op inside {alu_and, alu_xor, alu_or};
    assign is_sub   = alu.op inside {alu_sub, alu_sbc, alu_cp};

    // Signed overflow, operand signs compared against the result
    assign overflow = ((alu.lhs[7] ^ alu.rhs[7]) == is_sub) && (wide[7] != alu.lhs[7]);

    assign alu.result = wide[7:0];

    // --------------------------------------------------
    // Flags
    // --------------------------------------------------
    always_comb begin
        alu.flags         = '0;
        alu.flags[flag_s] = wide[7];
        alu.flags[flag_z] = (wide[7:0] == 8'h00);
        alu.flags[5]      = wide[5];
        alu.flags[3]      = wide[3];
        if (is_logic) begin
            // Even parity
            alu.flags[flag_p] = ~^wide[7:0];
        end else begin
            alu.flags[flag_a] = alu.lhs[4] ^ alu.rhs[4] ^ wide[4];
            alu.flags[flag_p] = overflow;
            alu.flags[flag_n] = is_sub;
            alu.flags[flag_c] = wide[8];
        end
    end

endmodule

//--- verilog/alu_if.sv
`timescale 1ns/1ps

interface alu_if;
    import bus_pkg::*;
    import isa_pkg::*;

    alu_op_e op;
    data_t   lhs;
    data_t   rhs;
    logic    carry_in;
    data_t   result;
    flags_t  flags;

    // Sequencer picks the operation and takes the results
    modport driver  (output op, input result, flags);
    // Register file supplies A, the operand and carry
    modport source  (output lhs, rhs, carry_in);
    modport compute (input op, lhs, rhs, carry_in, output result, flags);

endinterface

//--- verilog/bus_pkg.sv
package bus_pkg;

    // Memory bus widths
    typedef logic [15:0] addr_t;
    typedef logic [7:0]  data_t;

    // Program counter after reset
    localparam addr_t reset_pc = 16'h0000;

endpackage

//--- verilog/isa_pkg.sv
package isa_pkg;

    // Register numbers as coded in the opcode fields
    typedef logic [2:0] reg_sel_t;

    localparam reg_sel_t reg_b = 3'd0;
    localparam reg_sel_t reg_c = 3'd1;
    localparam reg_sel_t reg_d = 3'd2;
    localparam reg_sel_t reg_e = 3'd3;
    localparam reg_sel_t reg_h = 3'd4;
    localparam reg_sel_t reg_l = 3'd5;
    localparam reg_sel_t reg_m = 3'd6;
    localparam reg_sel_t reg_a = 3'd7;

    // ALU operations in opcode order, bits 5:3
    typedef enum logic [2:0] {
        alu_add, alu_adc, alu_sub, alu_sbc,
        alu_and, alu_xor, alu_or,  alu_cp
    } alu_op_e;

    // Flag byte, S Z 5 A 3 P N C
    typedef logic [7:0] flags_t;

    localparam int flag_c = 0;
    localparam int flag_n = 1;
    localparam int flag_p = 2;
    localparam int flag_a = 4;
    localparam int flag_z = 6;
    localparam int flag_s = 7;

    // Cycle within an instruction
    typedef enum logic [1:0] {t0, t1, t2} t_state_e;

    // Opcode groups, bits 7:6
    localparam logic [1:0] grp_misc = 2'b00;
    localparam logic [1:0] grp_load = 2'b01;
    localparam logic [1:0] grp_alu  = 2'b10;
    localparam logic [1:0] grp_ctrl = 2'b11;

    // Bits 2:0 of JP cc,**
    localparam logic [2:0] src_jp_cc = 3'b010;

    localparam logic [7:0] op_halt = 8'h76;
    localparam logic [7:0] op_jp   = 8'hC3;

endpackage

//--- verilog/kr580_core.sv
`timescale 1ns/1ps

module kr580_core
(
    input  logic           clock,
    input  logic           reset_n,
    input  bus_pkg::data_t in,
    output bus_pkg::addr_t address,
    output logic           we,
    output bus_pkg::data_t out
);
    import bus_pkg::*;
    import isa_pkg::*;

    addr_t  hl;
    data_t  src_data;
    data_t  dst_data;
    data_t  opcode;
    flags_t flags;

    reg_wr_if wr_bus (.reset_n(reset_n));
    alu_if    alu_bus ();

    sequencer u_sequencer (
        .clock    (clock),
        .reset_n  (reset_n),
        .in       (in),
        .address  (address),
        .we       (we),
        .out      (out),
        .hl       (hl),
        .src_data (src_data),
        .dst_data (dst_data),
        .flags    (flags),
        .opcode   (opcode),
        .wr       (wr_bus.sender),
        .alu      (alu_bus.driver)
    );

    register_file u_register_file (
        .clock    (clock),
        .in       (in),
        .opcode   (opcode),
        .src_data (src_data),
        .dst_data (dst_data),
        .hl       (hl),
        .flags    (flags),
        .wr       (wr_bus.receiver),
        .alu      (alu_bus.source)
    );

    alu u_alu (
        .alu (alu_bus.compute)
    );

endmodule

//--- verilog/reg_wr_if.sv
`timescale 1ns/1ps

interface reg_wr_if
(
    input logic reset_n
);
    import bus_pkg::*;
    import isa_pkg::*;

    // Byte write-back into one register
    logic     wr_byte;
    reg_sel_t wr_sel;
    data_t    wr_data;

    // Flag write-back
    logic     wr_flags;
    flags_t   flags_data;

    modport sender   (output wr_byte, wr_sel, wr_data, wr_flags, flags_data);
    modport receiver (input reset_n, wr_byte, wr_sel, wr_data, wr_flags, flags_data);

endinterface

//--- verilog/register_file.sv
`timescale 1ns/1ps

module register_file
(
    input  logic            clock,
    input  bus_pkg::data_t  in,
    input  bus_pkg::data_t  opcode,
    output bus_pkg::data_t  src_data,
    output bus_pkg::data_t  dst_data,
    output bus_pkg::addr_t  hl,
    output isa_pkg::flags_t flags,
    reg_wr_if.receiver      wr,
    alu_if.source           alu
);
    import bus_pkg::*;
    import isa_pkg::*;

    data_t  b, c, d, e, h, l, a;
    flags_t f;
    data_t  target;

    // M reads the memory byte on the bus
    function automatic data_t pick(input reg_sel_t sel);
        case (sel)
            reg_b:   return b;
            reg_c:   return c;
            reg_d:   return d;
            reg_e:   return e;
            reg_h:   return h;
            reg_l:   return l;
            reg_m:   return in;
            default: return a;
        endcase
    endfunction

    always_comb begin
        src_data = pick(opcode[2:0]);
        target   = pick(opcode[5:3]);
    end

    // INC when bit 0 is clear, DEC when set
    assign dst_data = opcode[0] ? target - 8'd1 : target + 8'd1;

    assign hl           = {h, l};
    assign flags        = f;
    assign alu.lhs      = a;
    assign alu.rhs      = src_data;
    assign alu.carry_in = f[flag_c];

    // Write-back lands half a cycle after the strobe
    always_ff @(negedge clock) begin
        if (!wr.reset_n) begin
            {b, c, d, e, h, l, a} <= '0;
            f <= '0;
        end else begin
            if (wr.wr_byte) begin
                case (wr.wr_sel)
                    reg_b:   b <= wr.wr_data;
                    reg_c:   c <= wr.wr_data;
                    reg_d:   d <= wr.wr_data;
                    reg_e:   e <= wr.wr_data;
                    reg_h:   h <= wr.wr_data;
                    reg_l:   l <= wr.wr_data;
                    reg_a:   a <= wr.wr_data;
                    default: ;
                endcase
            end
            if (wr.wr_flags) begin
                f <= wr.flags_data;
            end
        end
    end

endmodule

//--- verilog/sequencer.sv
`timescale 1ns/1ps

module sequencer
(
    input  logic            clock,
    input  logic            reset_n,
    input  bus_pkg::data_t  in,
    output bus_pkg::addr_t  address,
    output logic            we,
    output bus_pkg::data_t  out,
    input  bus_pkg::addr_t  hl,
    input  bus_pkg::data_t  src_data,
    input  bus_pkg::data_t  dst_data,
    input  isa_pkg::flags_t flags,
    output bus_pkg::data_t  opcode,
    reg_wr_if.sender        wr,
    alu_if.driver           alu
);
    import bus_pkg::*;
    import isa_pkg::*;

    t_state_e   state;
    addr_t      pc;
    data_t      latch;
    data_t      jp_low;
    logic       sel_hl;

    logic [1:0] op_grp;
    logic [2:0] op_dst;
    logic [2:0] op_src;
    logic       is_jp;
    logic       jp_taken;
    logic       cond_true;
    flags_t     id_flags;

    // Opcode comes straight off the bus in t0
    assign opcode  = (state == t0) ? in : latch;
    assign address = sel_hl ? hl : pc;

    assign op_grp = opcode[7:6];
    assign op_dst = opcode[5:3];
    assign op_src = opcode[2:0];
    assign alu.op = alu_op_e'(op_dst);

    // --------------------------------------------------
    // Jump condition NZ, Z, NC, C
    // --------------------------------------------------
    always_comb begin
        case (op_dst[1:0])
            2'd0:    cond_true = ~flags[flag_z];
            2'd1:    cond_true = flags[flag_z];
            2'd2:    cond_true = ~flags[flag_c];
            default: cond_true = flags[flag_c];
        endcase
    end

    // Only the four low conditions are decoded
    assign is_jp = (opcode == op_jp)
                 || (op_grp == grp_ctrl && op_src == src_jp_cc && !op_dst[2]);
    assign jp_taken = (opcode == op_jp) || cond_true;

    // INC/DEC flags, derived from the new value
    always_comb begin
        id_flags         = flags;
        id_flags[flag_s] = dst_data[7];
        id_flags[flag_z] = (dst_data == 8'h00);
        id_flags[5]      = dst_data[5];
        id_flags[3]      = dst_data[3];
        id_flags[flag_n] = opcode[0];
        id_flags[flag_a] = opcode[0] ? (dst_data[3:0] == 4'hF) : (dst_data[3:0] == 4'h0);
        id_flags[flag_p] = opcode[0] ? (dst_data == 8'h7F) : (dst_data == 8'h80);
    end

    task automatic put_reg(input reg_sel_t sel, input data_t data);
        wr.wr_byte <= 1'b1;
        wr.wr_sel  <= sel;
        wr.wr_data <= data;
    endtask

    // CP keeps A but still updates F
    task automatic put_alu();
        wr.wr_byte    <= (alu.op != alu_cp);
        wr.wr_sel     <= reg_a;
        wr.wr_data    <= alu.result;
        wr.wr_flags   <= 1'b1;
        wr.flags_data <= alu.flags;
    endtask

    // --------------------------------------------------
    // T-state machine
    // --------------------------------------------------
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state       <= t0;
            pc          <= reset_pc;
            sel_hl      <= 1'b0;
            we          <= 1'b0;
            wr.wr_byte  <= 1'b0;
            wr.wr_flags <= 1'b0;
        end else begin
            we          <= 1'b0;
            sel_hl      <= 1'b0;
            wr.wr_byte  <= 1'b0;
            wr.wr_flags <= 1'b0;
            state       <= t0;

            case (state)
                t0: begin
                    latch <= in;
                    pc    <= pc + 16'd1;
                    case (op_grp)
                        grp_misc: begin
                            if (op_src == reg_m && op_dst != reg_m) begin
                                state <= t1;
                            end else if (op_src[2:1] == 2'b10 && op_dst != reg_m) begin
                                put_reg(op_dst, dst_data);
                                wr.wr_flags   <= 1'b1;
                                wr.flags_data <= id_flags;
                            end
                        end
                        grp_load: begin
                            if (opcode == op_halt) begin
                                pc <= pc;
                            end else if (op_dst == reg_m) begin
                                // Store goes out next cycle at HL
                                sel_hl <= 1'b1;
                                we     <= 1'b1;
                                out    <= src_data;
                                state  <= t1;
                            end else if (op_src == reg_m) begin
                                sel_hl <= 1'b1;
                                state  <= t1;
                            end else begin
                                put_reg(op_dst, src_data);
                            end
                        end
                        grp_alu: begin
                            if (op_src == reg_m) begin
                                sel_hl <= 1'b1;
                                state  <= t1;
                            end else begin
                                put_alu();
                            end
                        end
                        default: begin
                            if (is_jp) begin
                                if (jp_taken) begin
                                    state <= t1;
                                end else begin
                                    pc <= pc + 16'd3;
                                end
                            end else if (op_src == reg_m) begin
                                state <= t1;
                            end
                        end
                    endcase
                end
                t1: begin
                    case (op_grp)
                        grp_misc: begin
                            put_reg(op_dst, src_data);
                            pc <= pc + 16'd1;
                        end
                        grp_load: begin
                            if (op_dst != reg_m) begin
                                put_reg(op_dst, src_data);
                            end
                        end
                        grp_alu: begin
                            put_alu();
                        end
                        default: begin
                            pc <= pc + 16'd1;
                            if (is_jp) begin
                                jp_low <= in;
                                state  <= t2;
                            end else begin
                                put_alu();
                            end
                        end
                    endcase
                end
                default: begin
                    // High byte of the jump target
                    pc <= {in, jp_low};
                end
            endcase
        end
    end

endmodule
